// File: vid_top.f
+incdir+.
vid_bus_pkg.sv
vid_pixel_pkg.sv
vid_apb_regs.sv
vid_main_ram.sv
vid_line_fetcher.sv
vid_line_buffer.sv
vid_pixel_out.sv
vid_top.sv
vid_checker.sv
vid_tb_clk.sv
vid_tb.sv

// File: Bender.yml
package:
  name: vid

sources:
  - include_dirs:
      - .
    files:
      - vid_bus_pkg.sv
      - vid_pixel_pkg.sv
      - vid_apb_regs.sv
      - vid_main_ram.sv
      - vid_line_fetcher.sv
      - vid_line_buffer.sv
      - vid_pixel_out.sv
      - vid_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - vid_checker.sv
      - vid_tb_clk.sv
      - vid_tb.sv

// File: vid_tb.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_tb;

    // Roughly 1400 APB accesses of 3 cycles and a few pixel lines, about 5000 cycles
    localparam int MAX_CYCLES = 20000;
    localparam int RAM_BYTES  = 4 * `VID_RAM_WORDS;
    localparam int N_RND      = 24;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;
    logic        frame_start;
    logic        line_start;
    logic        pixel_req;
    logic [11:0] rgb;
    logic        rgb_valid;

    // Reference model of RAM bytes, palette bytes and control registers
    logic [7:0]  ref_ram [RAM_BYTES];
    logic [7:0]  ref_pal [2*`VID_PAL_ENTRIES];
    logic        ref_en;
    logic [11:0] ref_base;

    logic [31:0] lfsr_state = 32'hedb6_8553;
    int unsigned cycles     = 0;
    int unsigned stalls     = 0;
    int          checks     = 0;
    int          errors     = 0;
    int          test_num   = 0;
    int          test_err0  = 0;
    logic [11:0] exp_rgb_q [$];
    int unsigned exp_cyc_q [$];
    logic [11:0] exp_rgb;
    int unsigned exp_cyc;
    logic [13:0] rnd_addr [N_RND];

    vid_tb_clk u_clk (
        .clk_o   (clk),
        .reset_o (reset)
    );

    vid_top dut (
        .clk           (clk),
        .reset         (reset),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .frame_start_i (frame_start),
        .line_start_i  (line_start),
        .pixel_req_i   (pixel_req),
        .rgb_o         (rgb),
        .rgb_valid_o   (rgb_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Random numbers and reference functions
    //////////////////////////////////////////////////////////////////////

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic region_none(input logic [15:0] a);
        return !(a[15:12] < 4'h4 || a[15:12] == 4'h8 || a[15:12] == 4'h9);
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] a);
        if (a[15:12] < 4'h4) begin
            return ref_ram[a[13:0]];
        end else if (a[15:12] == 4'h9) begin
            return ref_pal[a[8:0]];
        end else if (a[7:0] == 8'h00) begin
            return {7'b0, ref_en};
        end else if (a[7:0] == 8'h04) begin
            return ref_base[7:0];
        end
        return {4'b0, ref_base[11:8]};
    endfunction

    // Byte address of pixel k of a line in the frame buffer
    function automatic logic [13:0] line_byte(input int line, input int k);
        logic [11:0] word;
        word = ref_base + 12'(line * `VID_LINE_WORDS) + 12'(k / 4);
        return {word, 2'(k % 4)};
    endfunction

    // Entry bits 11 to 0 are the colour, high byte carries red
    function automatic logic [11:0] exp_colour(input int line, input int k);
        logic [7:0] idx;
        idx = ref_en ? ref_ram[line_byte(line, k)] : 8'h00;
        return {ref_pal[{idx, 1'b1}][3:0], ref_pal[{idx, 1'b0}]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks, bus tasks and strobes
    //////////////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic ref_write(input logic [15:0] a, input logic [7:0] d);
        if (a[15:12] < 4'h4) begin
            ref_ram[a[13:0]] = d;
        end else if (a[15:12] == 4'h9) begin
            ref_pal[a[8:0]] = d;
        end else if (a[15:12] == 4'h8) begin
            case (a[7:0])
                8'h00:   ref_en = d[0];
                8'h04:   ref_base[7:0] = d;
                8'h05:   ref_base[11:8] = d[3:0];
                default: ;
            endcase
        end
    endtask

    // Setup cycle, then two access cycles with pready in the second
    task automatic apb_access(input logic wr, input logic [15:0] a, input logic [7:0] d,
                              output logic [7:0] rdata);
        int waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!pready && waits < 4);
        rdata = prdata;
        if (!pready) begin
            errors++;
            $display("pready_o never rose during the access to %h", a);
        end else begin
            check("pready_o access cycle", waits, 2);
            check($sformatf("pslverr_o @%h", a), pslverr, region_none(a));
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] rd;
        apb_access(1'b1, a, d, rd);
        ref_write(a, d);
    endtask

    task automatic apb_read(input logic [15:0] a);
        logic [7:0] rd;
        apb_access(1'b0, a, 8'h00, rd);
        if (!region_none(a)) begin
            check($sformatf("prdata_o @%h", a), rd, ref_read(a));
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic strobe_line();
        line_start = 1'b1;
        idle(1);
        line_start = 1'b0;
    endtask

    task automatic strobe_frame();
        frame_start = 1'b1;
        idle(1);
        frame_start = 1'b0;
    endtask

    task automatic fill_line(input int line);
        for (int k = 0; k < `VID_LINE_PIXELS; k++) begin
            apb_write({2'b00, line_byte(line, k)}, 8'(rand_bits(8)));
        end
    endtask

    // One request per cycle, expected colour queued for the compare process
    task automatic request_line(input int line);
        for (int k = 0; k < `VID_LINE_PIXELS; k++) begin
            pixel_req = 1'b1;
            exp_rgb_q.push_back(exp_colour(line, k));
            exp_cyc_q.push_back(cycles);
            idle(1);
        end
        pixel_req = 1'b0;
    endtask

    task automatic start_test();
        test_num++;
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        idle(4);
        if (exp_rgb_q.size() != 0) begin
            errors++;
            $display("%0d requested pixels never came out", exp_rgb_q.size());
            exp_rgb_q.delete();
            exp_cyc_q.delete();
        end
        if (errors == test_err0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_num, name, errors - test_err0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cycles <= cycles + 1;
        // Host request while the fetcher asks means a stalled fetch
        if (dut.fetch_req && dut.host_req) begin
            stalls <= stalls + 1;
        end
    end

    always @(negedge clk) begin
        if (!reset && rgb_valid) begin
            if (exp_rgb_q.size() == 0) begin
                errors++;
                $display("rgb_valid_o high at %0t with no pixel request pending", $time);
            end else begin
                exp_rgb = exp_rgb_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                check("rgb_o", rgb, exp_rgb);
                check("rgb_valid_o delay", cycles - exp_cyc, 2);
            end
        end
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("run stopped after %0d cycles before the tests finished", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        int unsigned stall0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        frame_start = 1'b0;
        line_start  = 1'b0;
        pixel_req   = 1'b0;
        @(negedge reset);
        idle(1);

        start_test();
        for (int i = 0; i < N_RND; i++) begin
            rnd_addr[i] = 14'(rand_bits(14));
            apb_write({2'b00, rnd_addr[i]}, 8'(rand_bits(8)));
        end
        for (int i = 0; i < N_RND; i++) begin
            apb_read({2'b00, rnd_addr[i]});
        end
        end_test("ram byte readback");

        // Whole palette, later tests index any entry
        start_test();
        for (int i = 0; i < 2 * `VID_PAL_ENTRIES; i++) begin
            apb_write(16'h9000 + 16'(i), 8'(rand_bits(8)));
        end
        for (int i = 0; i < 2 * `VID_PAL_ENTRIES; i++) begin
            apb_read(16'h9000 + 16'(i));
        end
        end_test("palette readback");

        start_test();
        apb_write(16'h8004, 8'h5a);
        apb_write(16'h8005, 8'hff);
        apb_write(16'h8000, 8'h01);
        apb_read(16'h8000);
        apb_read(16'h8004);
        apb_read(16'h8005);
        apb_write(16'h0010, 8'h3c);
        // Unmapped pages aliasing RAM, palette and control offsets
        apb_write(16'h4010, 8'hc3);
        apb_write(16'hb001, 8'h77);
        apb_write(16'hf000, 8'h00);
        apb_read(16'ha005);
        apb_read(16'h0010);
        apb_read(16'h9001);
        apb_read(16'h8000);
        end_test("control and unmapped");

        start_test();
        apb_write(16'h8004, 8'(rand_bits(8)));
        apb_write(16'h8005, 8'(rand_bits(4)));
        apb_write(16'h8000, 8'h01);
        fill_line(0);
        fill_line(1);
        strobe_frame();
        strobe_line();
        idle(70);
        strobe_line();
        request_line(0);
        idle(70);
        strobe_line();
        request_line(1);
        end_test("displayed lines");

        start_test();
        apb_write(16'h8000, 8'h00);
        strobe_line();
        request_line(0);
        end_test("layer disabled");

        start_test();
        apb_write(16'h8004, 8'(rand_bits(8)));
        apb_write(16'h8005, 8'(rand_bits(4)));
        fill_line(0);
        apb_write(16'h8000, 8'h01);
        strobe_frame();
        stall0 = stalls;
        strobe_line();
        // Host reads every third cycle while line 0 is fetched
        for (int k = 0; k < 12; k++) begin
            apb_read({2'b00, line_byte(0, k)});
        end
        if (stalls == stall0) begin
            errors++;
            $display("the fetch was never stalled by host reads");
        end
        idle(40);
        strobe_line();
        request_line(0);
        end_test("fetch under host traffic");

        errors += int'(dut.u_checker.fail_cnt);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vid_tb_clk.sv
`timescale 1ns/1ps

module vid_tb_clk #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Released just after an edge so no input sees it change on the edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

// File: vid_checker.sv
`timescale 1ns/1ps

module vid_checker (
    input logic clk,
    input logic reset,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic pixel_req_i,
    input logic rgb_valid_i
);

    int unsigned fail_cnt = 0;

    // Ready only in the second cycle of an access phase
    a_pready_second: assert property (@(posedge clk) disable iff (reset)
        $rose(pready_i) |-> psel_i && penable_i && $past(psel_i && penable_i))
    else begin
        fail_cnt++;
        $error("pready_o rose outside the second access cycle");
    end

    a_pslverr_ready: assert property (@(posedge clk) disable iff (reset)
        pslverr_i |-> pready_i)
    else begin
        fail_cnt++;
        $error("pslverr_o high without pready_o");
    end

    //////////////////////////////////////////////////////////////////////
    // Pixel pipeline, fixed latency of two cycles
    //////////////////////////////////////////////////////////////////////
    a_rgb_after_req: assert property (@(posedge clk) disable iff (reset)
        pixel_req_i |-> ##2 rgb_valid_i)
    else begin
        fail_cnt++;
        $error("rgb_valid_o missing two cycles after pixel_req_i");
    end

    a_rgb_has_req: assert property (@(posedge clk) disable iff (reset)
        rgb_valid_i |-> $past(pixel_req_i, 2))
    else begin
        fail_cnt++;
        $error("rgb_valid_o without pixel_req_i two cycles before");
    end

endmodule

bind vid_top vid_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pready_i    (pready_o),
    .pslverr_i   (pslverr_o),
    .pixel_req_i (pixel_req_i),
    .rgb_valid_i (rgb_valid_o)
);

// File: vid_top.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_top (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`VID_PADDR_W-1:0]   paddr_i,
    input  logic [7:0]                pwdata_i,
    output logic [7:0]                prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    input  logic                      frame_start_i,
    input  logic                      line_start_i,
    input  logic                      pixel_req_i,
    output vid_pixel_pkg::rgb_t       rgb_o,
    output logic                      rgb_valid_o
);

    import vid_bus_pkg::*;
    import vid_pixel_pkg::*;

    // Host port
    logic           host_req;
    logic           host_we;
    ram_addr_t      host_addr;
    logic [31:0]    host_wdata;
    logic [3:0]     host_be;
    logic [31:0]    host_rdata;

    // Control
    logic           layer_en;
    ram_addr_t      fb_base;

    // Fetch port and line buffer
    logic           fetch_req;
    ram_addr_t      fetch_addr;
    logic           fetch_ack;
    logic [31:0]    fetch_rdata;
    logic           lb_we;
    line_word_idx_t lb_widx;
    logic [31:0]    lb_wdata;
    line_word_idx_t lb_ridx;
    logic [31:0]    lb_rdata;

    // Palette lookup
    pixel_idx_t     pal_raddr;
    palette_entry_u pal_rdata;

    vid_apb_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .host_req_o   (host_req),
        .host_we_o    (host_we),
        .host_addr_o  (host_addr),
        .host_wdata_o (host_wdata),
        .host_be_o    (host_be),
        .host_rdata_i (host_rdata),
        .layer_en_o   (layer_en),
        .fb_base_o    (fb_base),
        .pal_raddr_i  (pal_raddr),
        .pal_rdata_o  (pal_rdata)
    );

    vid_main_ram u_ram (
        .clk           (clk),
        .host_req_i    (host_req),
        .host_we_i     (host_we),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .host_be_i     (host_be),
        .host_rdata_o  (host_rdata),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .fetch_ack_o   (fetch_ack),
        .fetch_rdata_o (fetch_rdata)
    );

    vid_line_fetcher u_fetcher (
        .clk           (clk),
        .reset         (reset),
        .frame_start_i (frame_start_i),
        .line_start_i  (line_start_i),
        .layer_en_i    (layer_en),
        .fb_base_i     (fb_base),
        .fetch_req_o   (fetch_req),
        .fetch_addr_o  (fetch_addr),
        .fetch_ack_i   (fetch_ack),
        .fetch_rdata_i (fetch_rdata),
        .lb_we_o       (lb_we),
        .lb_widx_o     (lb_widx),
        .lb_wdata_o    (lb_wdata)
    );

    vid_line_buffer u_line_buf (
        .clk          (clk),
        .reset        (reset),
        .line_start_i (line_start_i),
        .we_i         (lb_we),
        .widx_i       (lb_widx),
        .wdata_i      (lb_wdata),
        .ridx_i       (lb_ridx),
        .rdata_o      (lb_rdata)
    );

    vid_pixel_out u_pixel_out (
        .clk          (clk),
        .reset        (reset),
        .line_start_i (line_start_i),
        .pixel_req_i  (pixel_req_i),
        .layer_en_i   (layer_en),
        .lb_ridx_o    (lb_ridx),
        .lb_rdata_i   (lb_rdata),
        .pal_raddr_o  (pal_raddr),
        .pal_rdata_i  (pal_rdata),
        .rgb_o        (rgb_o),
        .rgb_valid_o  (rgb_valid_o)
    );

endmodule

// File: vid_pixel_out.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_pixel_out (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           line_start_i,
    input  logic                           pixel_req_i,
    input  logic                           layer_en_i,

    output vid_pixel_pkg::line_word_idx_t  lb_ridx_o,
    input  logic [31:0]                    lb_rdata_i,

    output vid_pixel_pkg::pixel_idx_t      pal_raddr_o,
    input  vid_pixel_pkg::palette_entry_u  pal_rdata_i,

    output vid_pixel_pkg::rgb_t            rgb_o,
    output logic                           rgb_valid_o
);

    import vid_pixel_pkg::*;

    localparam int CNT_W = $clog2(`VID_LINE_PIXELS);

    logic [CNT_W-1:0] pix_cnt;
    logic [1:0]       lane_q;
    logic             req_q;
    pixel_idx_t       lane_pix;

    //////////////////////////////////////////////////////////////////////
    // Stage 0: word read from the front bank
    //////////////////////////////////////////////////////////////////////
    assign lb_ridx_o = pix_cnt[CNT_W-1:2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pix_cnt     <= '0;
            req_q       <= 1'b0;
            rgb_valid_o <= 1'b0;
        end else begin
            if (line_start_i) begin
                pix_cnt <= '0;
            end else if (pixel_req_i) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            req_q       <= pixel_req_i;
            rgb_valid_o <= req_q;
        end
    end

    always_ff @(posedge clk) begin
        lane_q <= pix_cnt[1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1: byte select and palette address
    //////////////////////////////////////////////////////////////////////
    assign lane_pix    = lb_rdata_i[8*lane_q +: 8];
    assign pal_raddr_o = layer_en_i ? lane_pix : '0;

    // Stage 2: palette entry back, colour view
    assign rgb_o = pal_rdata_i.color.rgb;

endmodule

// File: vid_line_buffer.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_line_buffer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           line_start_i,

    input  logic                           we_i,
    input  vid_pixel_pkg::line_word_idx_t  widx_i,
    input  logic [31:0]                    wdata_i,

    input  vid_pixel_pkg::line_word_idx_t  ridx_i,
    output logic [31:0]                    rdata_o
);

    logic [31:0] mem [2][`VID_LINE_WORDS];
    logic        bank_sel;

    // bank_sel names the front bank, the fetcher fills the other one
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_sel <= 1'b0;
        end else if (line_start_i) begin
            bank_sel <= ~bank_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[~bank_sel][widx_i] <= wdata_i;
        end
        rdata_o <= mem[bank_sel][ridx_i];
    end

endmodule

// File: vid_line_fetcher.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_line_fetcher (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           frame_start_i,
    input  logic                           line_start_i,
    input  logic                           layer_en_i,
    input  vid_bus_pkg::ram_addr_t         fb_base_i,

    output logic                           fetch_req_o,
    output vid_bus_pkg::ram_addr_t         fetch_addr_o,
    input  logic                           fetch_ack_i,
    input  logic [31:0]                    fetch_rdata_i,

    output logic                           lb_we_o,
    output vid_pixel_pkg::line_word_idx_t  lb_widx_o,
    output logic [31:0]                    lb_wdata_o
);

    import vid_bus_pkg::*;
    import vid_pixel_pkg::*;

    localparam int LINE_SHIFT = $clog2(`VID_LINE_WORDS);
    localparam int LINE_CNT_W = `VID_RAM_AW - LINE_SHIFT;

    logic [LINE_CNT_W-1:0] line_cnt;
    logic [LINE_CNT_W-1:0] line_cur;
    ram_addr_t             line_base;
    logic                  busy;
    logic [LINE_SHIFT:0]   issue_cnt;
    logic                  issued_vld;
    line_word_idx_t        issued_idx;

    assign line_cur     = frame_start_i ? '0 : line_cnt;
    assign fetch_req_o  = busy & ~issue_cnt[LINE_SHIFT];
    assign fetch_addr_o = line_base + ram_addr_t'(issue_cnt[LINE_SHIFT-1:0]);

    // Ack answers the request of the previous cycle
    assign lb_we_o    = issued_vld & fetch_ack_i;
    assign lb_widx_o  = issued_idx;
    assign lb_wdata_o = fetch_rdata_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            line_cnt   <= '0;
            line_base  <= '0;
            busy       <= 1'b0;
            issue_cnt  <= '0;
            issued_vld <= 1'b0;
            issued_idx <= '0;
        end else if (line_start_i) begin
            // New line, also aborts a running fetch
            busy       <= layer_en_i;
            issue_cnt  <= '0;
            issued_vld <= 1'b0;
            line_base  <= fb_base_i + {line_cur, {LINE_SHIFT{1'b0}}};
            line_cnt   <= line_cur + 1'b1;
        end else begin
            // Frame start only rewinds the line count, a running fetch goes on
            if (frame_start_i) begin
                line_cnt <= '0;
            end
            if (!layer_en_i) begin
                busy       <= 1'b0;
                issued_vld <= 1'b0;
            end else if (busy) begin
                issued_vld <= fetch_req_o;
                issued_idx <= issue_cnt[LINE_SHIFT-1:0];
                // Missing ack means the host took the RAM, go back to that word
                if (issued_vld && !fetch_ack_i) begin
                    issue_cnt <= {1'b0, issued_idx};
                end else if (fetch_req_o) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (issued_vld && fetch_ack_i && (&issued_idx) && issue_cnt[LINE_SHIFT]) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: vid_main_ram.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_main_ram (
    input  logic                    clk,

    input  logic                    host_req_i,
    input  logic                    host_we_i,
    input  vid_bus_pkg::ram_addr_t  host_addr_i,
    input  logic [31:0]             host_wdata_i,
    input  logic [3:0]              host_be_i,
    output logic [31:0]             host_rdata_o,

    input  logic                    fetch_req_i,
    input  vid_bus_pkg::ram_addr_t  fetch_addr_i,
    output logic                    fetch_ack_o,
    output logic [31:0]             fetch_rdata_o
);

    import vid_bus_pkg::*;

    logic [31:0] mem [`VID_RAM_WORDS];
    logic [31:0] rdata_q;
    ram_addr_t   addr;
    logic        fetch_grant;

    // Host always wins, the fetcher keeps asking
    assign fetch_grant = fetch_req_i & ~host_req_i;
    assign addr        = host_req_i ? host_addr_i : fetch_addr_i;

    always_ff @(posedge clk) begin
        if (host_req_i && host_we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (host_be_i[lane]) begin
                    mem[addr][8*lane +: 8] <= host_wdata_i[8*lane +: 8];
                end
            end
        end
        rdata_q     <= mem[addr];
        fetch_ack_o <= fetch_grant;
    end

    // One read register shared by both ports
    assign host_rdata_o  = rdata_q;
    assign fetch_rdata_o = rdata_q;

endmodule

// File: vid_apb_regs.sv
`timescale 1ns/1ps

`include "vid_config.svh"

module vid_apb_regs (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [`VID_PADDR_W-1:0]        paddr_i,
    input  logic [7:0]                     pwdata_i,
    output logic [7:0]                     prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,

    output logic                           host_req_o,
    output logic                           host_we_o,
    output vid_bus_pkg::ram_addr_t         host_addr_o,
    output logic [31:0]                    host_wdata_o,
    output logic [3:0]                     host_be_o,
    input  logic [31:0]                    host_rdata_i,

    output logic                           layer_en_o,
    output vid_bus_pkg::ram_addr_t         fb_base_o,

    input  vid_pixel_pkg::pixel_idx_t      pal_raddr_i,
    output vid_pixel_pkg::palette_entry_u  pal_rdata_o
);

    import vid_bus_pkg::*;
    import vid_pixel_pkg::*;

    vid_region_e    region;
    logic           access_first;
    logic           ctrl_we;
    logic           pal_we;
    logic [15:0]    fb_base_ext;
    palette_entry_u pal_mem [`VID_PAL_ENTRIES];
    palette_entry_u pal_rb_q;

    always_comb begin
        if (paddr_i[15:12] < `VID_RAM_PAGES) begin
            region = REGION_RAM;
        end else if (paddr_i[15:12] == `VID_PAGE_CTRL) begin
            region = REGION_CTRL;
        end else if (paddr_i[15:12] == `VID_PAGE_PAL) begin
            region = REGION_PAL;
        end else begin
            region = REGION_NONE;
        end
    end

    // First cycle of the access phase, pready follows one cycle later
    assign access_first = psel_i & penable_i & ~pready_o;
    assign ctrl_we      = access_first & pwrite_i & (region == REGION_CTRL);
    assign pal_we       = access_first & pwrite_i & (region == REGION_PAL);

    //////////////////////////////////////////////////////////////////////
    // Main RAM host port
    //////////////////////////////////////////////////////////////////////
    assign host_req_o   = access_first & (region == REGION_RAM);
    assign host_we_o    = pwrite_i;
    assign host_addr_o  = paddr_i[13:2];
    assign host_wdata_o = {4{pwdata_i}};
    assign host_be_o    = 4'b0001 << paddr_i[1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pready_o   <= 1'b0;
            pslverr_o  <= 1'b0;
            layer_en_o <= 1'b0;
            fb_base_o  <= '0;
        end else begin
            pready_o  <= access_first;
            pslverr_o <= access_first & (region == REGION_NONE);
            if (ctrl_we) begin
                case (vid_ctrl_reg_e'(paddr_i[7:0]))
                    CTRL_ENABLE:     layer_en_o <= pwdata_i[0];
                    CTRL_FB_BASE_LO: fb_base_o[7:0] <= pwdata_i;
                    CTRL_FB_BASE_HI: fb_base_o[`VID_RAM_AW-1:8] <= pwdata_i[`VID_RAM_AW-9:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Palette with display and readback ports
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[paddr_i[8:1]].bytes[paddr_i[0]] <= pwdata_i;
        end
        pal_rdata_o <= pal_mem[pal_raddr_i];
        pal_rb_q    <= pal_mem[paddr_i[8:1]];
    end

    assign fb_base_ext = 16'(fb_base_o);

    // Read data is consumed in the cycle with pready high
    always_comb begin
        prdata_o = 8'h00;
        case (region)
            REGION_RAM:  prdata_o = host_rdata_i[8*paddr_i[1:0] +: 8];
            REGION_PAL:  prdata_o = pal_rb_q.bytes[paddr_i[0]];
            REGION_CTRL: begin
                case (vid_ctrl_reg_e'(paddr_i[7:0]))
                    CTRL_ENABLE:     prdata_o = {7'b0, layer_en_o};
                    CTRL_FB_BASE_LO: prdata_o = fb_base_ext[7:0];
                    CTRL_FB_BASE_HI: prdata_o = fb_base_ext[15:8];
                    default:         prdata_o = 8'h00;
                endcase
            end
            default: prdata_o = 8'h00;
        endcase
    end

endmodule

// File: vid_pixel_pkg.sv
package vid_pixel_pkg;

`include "vid_config.svh"

    typedef logic [`VID_PAL_IDX_W-1:0] pixel_idx_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Host side sees two bytes, display side sees a colour
    typedef union packed {
        logic [1:0][7:0] bytes;
        struct packed {
            logic [3:0] rsvd;
            rgb_t       rgb;
        } color;
    } palette_entry_u;

    // Word position within one line
    typedef logic [$clog2(`VID_LINE_WORDS)-1:0] line_word_idx_t;

endpackage

// File: vid_bus_pkg.sv
package vid_bus_pkg;

`include "vid_config.svh"

    // Region selected by the upper address nibble
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_CTRL,
        REGION_PAL,
        REGION_NONE
    } vid_region_e;

    // Byte offsets inside the control page
    typedef enum logic [7:0] {
        CTRL_ENABLE     = 8'h00,
        CTRL_FB_BASE_LO = 8'h04,
        CTRL_FB_BASE_HI = 8'h05
    } vid_ctrl_reg_e;

    // Word address into main RAM
    typedef logic [`VID_RAM_AW-1:0] ram_addr_t;

endpackage

// File: vid_config.svh
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// Line geometry
`define VID_LINE_PIXELS 64
`define VID_LINE_WORDS  16

// Main RAM, 32-bit words
`define VID_RAM_WORDS   4096
`define VID_RAM_AW      12

// Palette
`define VID_PAL_ENTRIES 256
`define VID_PAL_IDX_W   8

//////////////////////////////////////////////////////////////////////
// Address map, selected by paddr[15:12]
//////////////////////////////////////////////////////////////////////
`define VID_PADDR_W     16

// Pages 0x0 up to 0x3 are main RAM bytes
`define VID_RAM_PAGES   4'h4
`define VID_PAGE_CTRL   4'h8
`define VID_PAGE_PAL    4'h9

`endif
